// ==== src/rvCorePkg.sv ====
package rvCorePkg;

    localparam int xLen = 32;

    typedef logic [4:0] regIdx_t;

    // Kept major opcodes
    localparam logic [6:0] opR     = 7'h33;
    localparam logic [6:0] opImm   = 7'h13;
    localparam logic [6:0] opLoad  = 7'h03;
    localparam logic [6:0] opStore = 7'h23;

    localparam logic [31:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluSltu
    } aluOp_e;

    // One instruction word seen in R, I and S layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regIdx_t    rs2;
            regIdx_t    rs1;
            logic [2:0] funct3;
            regIdx_t    rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm12;
            regIdx_t     rs1;
            logic [2:0]  funct3;
            regIdx_t     rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            regIdx_t    rs2;
            regIdx_t    rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
    } instrWord_u;

    typedef enum logic [1:0] {fromRegFile, fromMem, fromWb} fwdSel_e;

    typedef struct packed {
        logic            regWe;     // Set only for a nonzero rd
        regIdx_t         rd;
        logic            isLoad;
        logic            isStore;
        logic [xLen-1:0] aluResult; // Also the byte address of a load or store
        logic [xLen-1:0] storeData;
    } exMemReg_t;

    typedef struct packed {
        logic            regWe;
        regIdx_t         rd;
        logic            isLoad;
        logic [xLen-1:0] aluResult;
        logic [xLen-1:0] loadData;
    } memWbReg_t;

    typedef struct packed {
        logic            we;
        logic [9:0]      addr;  // Byte address
        logic [xLen-1:0] wdata;
    } ramReq_t;

endpackage

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import rvCorePkg::*; (
    input  logic [xLen-1:0] a,
    input  logic [xLen-1:0] b,
    input  aluOp_e          op,
    output logic [xLen-1:0] y
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluXor:  y = a ^ b;
            aluSll:  y = a << shamt;
            aluSrl:  y = a >> shamt;
            aluSra:  y = $signed(a) >>> shamt; // Sign bit fills from the left
            aluSlt:  y = {{(xLen-1){1'b0}}, ltSigned};
            aluSltu: y = {{(xLen-1){1'b0}}, ltUnsigned};
            default: y = '0;
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvCorePkg::*; (
    input  logic            CLK,
    input  regIdx_t         rs1,
    input  regIdx_t         rs2,
    output logic [xLen-1:0] rs1Data,
    output logic [xLen-1:0] rs2Data,
    input  logic            we,
    input  regIdx_t         rd,
    input  logic [xLen-1:0] wdata
);

    logic [xLen-1:0] regs [32];

    // x0 never stored, so its read is forced to zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge CLK) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle read of a register being written returns the old value
    // The writeback forwarding path in execute covers that case

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import rvCorePkg::*; (
    input  instrWord_u idInstr,
    input  instrWord_u exInstr,
    input  exMemReg_t  exMem,
    input  memWbReg_t  memWb,
    output logic       stall,
    output fwdSel_e    fwdA,
    output fwdSel_e    fwdB
);

    logic idUsesRs1;
    logic idUsesRs2;
    logic exIsLoad;

    // Memory stage beats writeback since it holds the younger result
    function automatic fwdSel_e pickSrc(regIdx_t rs, exMemReg_t em, memWbReg_t mw);
        if (rs == '0) return fromRegFile;
        if (em.regWe && !em.isLoad && em.rd == rs) return fromMem;
        if (mw.regWe && mw.rd == rs) return fromWb;
        return fromRegFile;
    endfunction

    always_comb begin
        fwdA = pickSrc(exInstr.rFmt.rs1, exMem, memWb);
        fwdB = pickSrc(exInstr.rFmt.rs2, exMem, memWb);
    end

    assign exIsLoad  = exInstr.iFmt.opcode == opLoad;
    assign idUsesRs2 = idInstr.rFmt.opcode == opR || idInstr.rFmt.opcode == opStore;
    assign idUsesRs1 = idUsesRs2 || idInstr.iFmt.opcode == opImm
                       || idInstr.iFmt.opcode == opLoad;

    // Load result only exists after the memory stage
    assign stall = exIsLoad && exInstr.iFmt.rd != '0
                   && ((idUsesRs1 && idInstr.rFmt.rs1 == exInstr.iFmt.rd)
                       || (idUsesRs2 && idInstr.rFmt.rs2 == exInstr.iFmt.rd));

endmodule

// ==== src/fetchDecode.sv ====
`timescale 1ns/1ps

module fetchDecode import rvCorePkg::*; #(
    parameter int addrBits = 10
) (
    input  logic                CLK,
    input  logic                rstN,
    input  logic [xLen-1:0]     instr,
    input  logic                stall,
    output logic [addrBits-1:0] instrAddr,
    output instrWord_u          idInstr
);

    logic [addrBits-1:0] pc; // Word address into the ROM

    assign instrAddr = pc;

    // Without branches the PC only advances or holds
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // Decode register keeps its word while a load-use bubble goes into execute
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            idInstr <= nopWord;
        end else if (!stall) begin
            idInstr <= instr;
        end
    end

    // Stalled fetch must not skip the held instruction
    pcHoldOnStall: assert property (
        @(posedge CLK) disable iff (!rstN)
        stall |=> $stable(instrAddr)
    );

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import rvCorePkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  instrWord_u      idInstr,
    input  logic            stall,
    input  fwdSel_e         fwdA,
    input  fwdSel_e         fwdB,
    input  logic [xLen-1:0] wbData,
    input  logic [xLen-1:0] rs1Data,
    input  logic [xLen-1:0] rs2Data,
    output instrWord_u      exInstr,
    output exMemReg_t       exMem
);

    logic            isR;
    logic            isImm;
    logic            isLoad;
    logic            isStore;
    aluOp_e          aluOp;
    logic [xLen-1:0] immI;
    logic [xLen-1:0] immS;
    logic [xLen-1:0] opA;
    logic [xLen-1:0] opB;
    logic [xLen-1:0] aluY;
    exMemReg_t       exNext;

    function automatic logic [xLen-1:0] pickOperand(fwdSel_e sel, logic [xLen-1:0] rfData,
                                                    logic [xLen-1:0] memData,
                                                    logic [xLen-1:0] wbVal);
        case (sel)
            fromMem: return memData;
            fromWb:  return wbVal;
            default: return rfData;
        endcase
    endfunction

    always_ff @(posedge CLK) begin
        if (!rstN || stall) begin
            exInstr <= nopWord; // Bubble behind a load
        end else begin
            exInstr <= idInstr;
        end
    end

    assign isR     = exInstr.rFmt.opcode == opR;
    assign isImm   = exInstr.iFmt.opcode == opImm;
    assign isLoad  = exInstr.iFmt.opcode == opLoad;
    assign isStore = exInstr.sFmt.opcode == opStore;

    always_comb begin
        aluOp = aluAdd; // Address math for loads and stores
        if (isR || isImm) begin
            case (exInstr.rFmt.funct3)
                3'h0: aluOp = (isR && exInstr.rFmt.funct7[5]) ? aluSub : aluAdd;
                3'h1: aluOp = aluSll;
                3'h2: aluOp = aluSlt;
                3'h3: aluOp = aluSltu;
                3'h4: aluOp = aluXor;
                3'h5: aluOp = exInstr.rFmt.funct7[5] ? aluSra : aluSrl; // srai too
                3'h6: aluOp = aluOr;
                default: aluOp = aluAnd;
            endcase
        end
    end

    assign immI = {{(xLen-12){exInstr.iFmt.imm12[11]}}, exInstr.iFmt.imm12};
    assign immS = {{(xLen-12){exInstr.sFmt.immHi[6]}}, exInstr.sFmt.immHi, exInstr.sFmt.immLo};

    assign opA = pickOperand(fwdA, rs1Data, exMem.aluResult, wbData);
    assign opB = isR ? pickOperand(fwdB, rs2Data, exMem.aluResult, wbData)
                     : (isStore ? immS : immI);

    aluUnit alu (
        .a  (opA),
        .b  (opB),
        .op (aluOp),
        .y  (aluY)
    );

    always_comb begin
        exNext.regWe     = (isR || isImm || isLoad) && exInstr.rFmt.rd != '0;
        exNext.rd        = exInstr.rFmt.rd;
        exNext.isLoad    = isLoad;
        exNext.isStore   = isStore;
        exNext.aluResult = aluY;
        exNext.storeData = pickOperand(fwdB, rs2Data, exMem.aluResult, wbData);
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= exNext;
        end
    end

    // Forwarding from rd zero would corrupt x0 readers downstream
    noWriteToX0: assert property (
        @(posedge CLK) disable iff (!rstN)
        exMem.regWe |-> exMem.rd != '0
    );

endmodule

// ==== src/memWriteback.sv ====
`timescale 1ns/1ps

module memWriteback import rvCorePkg::*; #(
    parameter int addrBits = 10
) (
    input  logic            CLK,
    input  logic            rstN,
    input  exMemReg_t       exMem,
    input  logic [xLen-1:0] ramRdata,
    output ramReq_t         ramReq,
    output logic [xLen-1:0] gpio,
    output memWbReg_t       memWb,
    output logic [xLen-1:0] wbData
);

    logic gpioHit;

    // Address 0 decoded on the same truncated bits the RAM sees
    assign gpioHit = exMem.aluResult[addrBits-1:0] == '0;

    always_comb begin
        ramReq.we                  = exMem.isStore && !gpioHit;
        ramReq.addr                = '0;
        ramReq.addr[addrBits-1:0]  = exMem.aluResult[addrBits-1:0];
        ramReq.wdata               = exMem.storeData;
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            gpio <= '0;
        end else if (exMem.isStore && gpioHit) begin
            gpio <= exMem.storeData;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.regWe     <= exMem.regWe;
            memWb.rd        <= exMem.rd;
            memWb.isLoad    <= exMem.isLoad;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= ramRdata; // RAM answers in the same cycle
        end
    end

    assign wbData = memWb.isLoad ? memWb.loadData : memWb.aluResult;

    // GPIO stores are kept off the RAM
    gpioNotInRam: assert property (
        @(posedge CLK) disable iff (!rstN)
        ramReq.we |-> ramReq.addr != '0
    );

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps

module rvCore import rvCorePkg::*; #(
    parameter int addrBits = 10
) (
    input  logic                CLK,
    input  logic                rstN,
    input  logic [xLen-1:0]     instr,
    output logic [addrBits-1:0] instrAddr,
    output ramReq_t             ramReq,
    input  logic [xLen-1:0]     ramRdata,
    output logic [xLen-1:0]     gpio
);

    instrWord_u      idInstr;
    instrWord_u      exInstr;
    exMemReg_t       exMem;
    memWbReg_t       memWb;
    logic            stall;
    fwdSel_e         fwdA;
    fwdSel_e         fwdB;
    logic [xLen-1:0] rs1Data;
    logic [xLen-1:0] rs2Data;
    logic [xLen-1:0] wbData;

    fetchDecode #(.addrBits(addrBits)) fetch (
        .CLK(CLK), .rstN(rstN), .instr(instr), .stall(stall),
        .instrAddr(instrAddr), .idInstr(idInstr)
    );

    hazardUnit hazard (
        .idInstr(idInstr), .exInstr(exInstr), .exMem(exMem), .memWb(memWb),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Register file is read in execute and written in writeback
    regFile regs (
        .CLK(CLK), .rs1(exInstr.rFmt.rs1), .rs2(exInstr.rFmt.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .we(memWb.regWe), .rd(memWb.rd), .wdata(wbData)
    );

    executeStage execute (
        .CLK(CLK), .rstN(rstN), .idInstr(idInstr), .stall(stall),
        .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .exInstr(exInstr), .exMem(exMem)
    );

    memWriteback #(.addrBits(addrBits)) memWb0 (
        .CLK(CLK), .rstN(rstN), .exMem(exMem), .ramRdata(ramRdata),
        .ramReq(ramReq), .gpio(gpio), .memWb(memWb), .wbData(wbData)
    );

endmodule

// ==== bench/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory import rvCorePkg::*; #(
    parameter int addrBits = 10
) (
    input  logic                CLK,
    input  logic [addrBits-1:0] instrAddr,
    output logic [xLen-1:0]     instr,
    input  ramReq_t             ramReq,
    output logic [xLen-1:0]     ramRdata
);

    logic [xLen-1:0] rom [1024]; // Filled by the bench before reset
    logic [xLen-1:0] ram [256];

    initial begin
        // Every word differs, built from its own index
        for (int i = 0; i < 256; i++) begin
            ram[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
    end

    assign instr    = rom[instrAddr];
    assign ramRdata = ram[ramReq.addr[9:2]]; // Byte address to word index

    always @(posedge CLK) begin
        if (ramReq.we) begin
            ram[ramReq.addr[9:2]] <= ramReq.wdata;
        end
    end

endmodule

// ==== bench/coreTb.sv ====
`timescale 1ns/1ps

module coreTb import rvCorePkg::*; ();

    localparam int addrBits = 10;
    localparam int maxCycles = 200; // About four times the program length

    logic                CLK;
    logic                rstN;
    logic                rstQ;
    logic [xLen-1:0]     instr;
    logic [addrBits-1:0] instrAddr;
    ramReq_t             ramReq;
    logic [xLen-1:0]     ramRdata;
    logic [xLen-1:0]     gpio;

    integer          seed;
    int              errors;
    int              cycles;
    int              progLen;
    logic [31:0]     prog [64];
    logic [31:0]     gpioExp [32];
    logic [31:0]     ramExp [16];
    int              gpioCnt;
    int              ramCnt;
    int              gpioSeen;
    int              ramIdx;
    logic            loadUseAt [1024];
    int              expHolds;
    int              holds;
    logic            gpioPend;
    logic [31:0]     gpioNow;
    logic [31:0]     ramExpNow;
    logic [addrBits-1:0] prevAddr;
    logic            prevHeld;

    rvCore #(.addrBits(addrBits)) uut (
        .CLK(CLK), .rstN(rstN), .instr(instr), .instrAddr(instrAddr),
        .ramReq(ramReq), .ramRdata(ramRdata), .gpio(gpio)
    );

    tbMemory #(.addrBits(addrBits)) mem (
        .CLK(CLK), .instrAddr(instrAddr), .instr(instr),
        .ramReq(ramReq), .ramRdata(ramRdata)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [2:0]  rF3 [10];
        logic [6:0]  rF7 [10];
        logic [2:0]  iF3 [9];
        logic [11:0] imm;
        logic [11:0] ramAddr;
        rF3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        rF7 = '{7'h0, 7'h20, 7'h0, 7'h0, 7'h0, 7'h0, 7'h0, 7'h20, 7'h0, 7'h0};
        iF3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        progLen = 0;
        for (int r = 1; r <= 3; r++) begin
            imm = 12'($random(seed));
            emit(encI(imm, 5'd0, 3'd0, 5'(r), opImm));
        end
        // Each x3 = x3 op x2 stored at once so both forwarding paths get used
        for (int i = 0; i < 10; i++) begin
            emit(encR(rF7[i], 5'd2, 5'd3, rF3[i], 5'd3));
            emit(encS(12'd0, 5'd3, 5'd0));
        end
        for (int i = 0; i < 9; i++) begin
            imm = 12'($random(seed));
            if (iF3[i] == 3'd1 || iF3[i] == 3'd5) begin
                imm[11:5] = (i == 8) ? 7'h20 : 7'h00; // Last one is srai
            end
            emit(encI(imm, 5'd3, iF3[i], 5'd3, opImm));
            emit(encS(12'd0, 5'd3, 5'd0));
        end
        ramAddr = 12'(4 * (1 + ($random(seed) & 63)));
        emit(encI(ramAddr, 5'd0, 3'd0, 5'd4, opImm));
        emit(encS(12'd0, 5'd3, 5'd4));
        emit(encI(12'd0, 5'd4, 3'd2, 5'd5, opLoad));
        emit(encS(12'd0, 5'd5, 5'd0)); // Uses the load right away
        imm = 12'($random(seed)) | 12'd1;
        emit(encI(imm, 5'd0, 3'd0, 5'd0, opImm));
        emit(encS(12'd0, 5'd0, 5'd0));
    endtask

    // Runs the program in order and records every expected store
    task automatic runModel();
        logic [31:0] xr [32];
        logic [31:0] ramM [256];
        logic [31:0] w;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [31:0] nxt;
        xr = '{default: 32'd0};
        ramM = '{default: 32'd0};
        gpioCnt = 0;
        ramCnt = 0;
        expHolds = 0;
        for (int pc = 0; pc < progLen; pc++) begin
            w = prog[pc];
            rd = w[11:7];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            nxt = prog[pc + 1];
            case (w[6:0])
                opR:   if (rd != 0) xr[rd] = aluRef(w[14:12], w[30], xr[w[19:15]], xr[w[24:20]]);
                opImm: if (rd != 0) xr[rd] = aluRef(w[14:12], w[30] && w[14:12] == 3'd5,
                                                     xr[w[19:15]], immI);
                opLoad: begin
                    addr = xr[w[19:15]] + immI;
                    if (rd != 0) xr[rd] = ramM[addr[9:2]];
                    if (rd != 0 && (nxt[19:15] == rd || ((nxt[6:0] == opR
                        || nxt[6:0] == opStore) && nxt[24:20] == rd))) begin
                        loadUseAt[pc] = 1'b1;
                        expHolds++;
                    end
                end
                default: begin
                    addr = xr[w[19:15]] + immS;
                    if (addr[9:0] == 0) begin
                        gpioExp[gpioCnt] = xr[w[24:20]];
                        gpioCnt++;
                    end else begin
                        ramM[addr[9:2]] = xr[w[24:20]];
                        ramExp[ramCnt] = xr[w[24:20]];
                        ramCnt++;
                    end
                end
            endcase
        end
    endtask

    assign ramExpNow = ramExp[ramIdx[3:0]];

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        rstQ <= rstN;
        gpioPend <= 1'b0;
        if (rstQ && uut.exMem.isStore && ramReq.addr == '0) begin
            gpioPend <= 1'b1;
            gpioNow <= gpioExp[gpioSeen[4:0]];
            gpioSeen <= gpioSeen + 1;
        end
        if (rstQ && ramReq.we) ramIdx <= ramIdx + 1;
        if (cycles == maxCycles) begin
            $display("Timeout: program did not finish within %0d cycles", maxCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(posedge CLK) begin
        prevAddr <= instrAddr;
        prevHeld <= rstQ && instrAddr == prevAddr;
        if (rstQ && instrAddr == prevAddr) holds <= holds + 1;
    end

    resetState: assert property (@(negedge CLK)
        !rstN |-> instrAddr == '0 && !ramReq.we && gpio == '0)
    else begin
        errors++;
        $display("FAILED reset state: instrAddr=%h ramReq.we=%h gpio=%h",
                 instrAddr, ramReq.we, gpio);
    end

    gpioValue: assert property (@(negedge CLK) disable iff (!rstQ)
        gpioPend |-> gpio == gpioNow)
    else begin
        errors++;
        $display("FAILED gpio: got %h expected %h", gpio, gpioNow);
    end

    ramWrite: assert property (@(negedge CLK) disable iff (!rstQ)
        ramReq.we |-> ramReq.wdata == ramExpNow)
    else begin
        errors++;
        $display("FAILED ramReq.wdata: got %h expected %h", ramReq.wdata, ramExpNow);
    end

    gpioOffRam: assert property (@(negedge CLK) disable iff (!rstQ)
        ramReq.we |-> ramReq.addr != '0)
    else begin
        errors++;
        $display("RAM write enable was high for the GPIO address");
    end

    // One hold allowed right after a load with a dependent successor
    fetchStep: assert property (@(negedge CLK) disable iff (!rstQ)
        instrAddr == prevAddr + 1'b1
        || (instrAddr == prevAddr && loadUseAt[prevAddr - 2'd2] && !prevHeld))
    else begin
        errors++;
        $display("FAILED instrAddr: got %h after %h", instrAddr, prevAddr);
    end

    initial begin
        seed = 86018;
        rstN = 1'b0;
        rstQ = 1'b0;
        errors = 0;
        cycles = 0;
        gpioSeen = 0;
        ramIdx = 0;
        holds = 0;
        gpioPend = 1'b0;
        gpioNow = '0;
        prevAddr = '0;
        prevHeld = 1'b0;
        for (int i = 0; i < 1024; i++) loadUseAt[i] = 1'b0;
        prog = '{default: nopWord};
        buildProgram();
        runModel();
        for (int i = 0; i < 1024; i++) mem.rom[i] = (i < 64) ? prog[i] : nopWord;
        repeat (2) @(posedge CLK);
        #1 rstN = 1'b1;
        wait (gpioSeen == gpioCnt);
        repeat (3) @(posedge CLK);
        assert (holds == expHolds) else begin
            errors++;
            $display("Fetch held for %0d cycles, expected %0d", holds, expHolds);
        end
        assert (ramIdx == ramCnt) else begin
            errors++;
            $display("Saw %0d RAM writes, expected %0d", ramIdx, ramCnt);
        end
        $display("Errors: %0d, gpio writes checked: %0d", errors, gpioSeen);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/rvCorePkg.sv
src/aluUnit.sv
src/regFile.sv
src/hazardUnit.sv
src/fetchDecode.sv
src/executeStage.sv
src/memWriteback.sv
src/rvCore.sv
bench/tbMemory.sv
bench/coreTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the core and its bench with Verilator, then run and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module coreTb -o coreSim \
    && ./obj_dir/coreSim | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
